/* hw/sys_arr_macros.svh */
`ifndef SYS_ARR_MACROS_SVH
`define SYS_ARR_MACROS_SVH

// array dimension, the engine computes one SA_N x SA_N product at a time
`define SA_N 4

// element width, every sum and product wraps at this width
`define SA_DATA_W 16

// iteration counter covers input, partial and drain steps
`define SA_ITER_W ($clog2(3 * `SA_N))

`endif

/* hw/sys_arr_pkg.sv */
`include "sys_arr_macros.svh"

package sys_arr_pkg;

    typedef logic signed [`SA_DATA_W-1:0] sa_elem_t;   // one matrix element
    typedef sa_elem_t [`SA_N-1:0] sa_row_t;            // element j at index j
    typedef logic [$clog2(`SA_N)-1:0] sa_idx_t;        // row number inside one GEMM

    // one row written by the host
    typedef struct packed {
        logic    en;
        sa_idx_t row_idx;
        sa_row_t data;
    } sa_load_t;

    typedef struct packed {
        logic mac_start;   // one grid step
        logic in_shift;    // input step, consume an input row
        logic ps_shift;    // partial step, pop product and partial rows
        logic add_start;   // drain step
        logic out_shift;   // drain step, pop a sum row
    } sa_ctrl_t;

    // one result row
    typedef struct packed {
        logic    valid;
        sa_idx_t row_idx;
        sa_row_t data;
    } sa_out_t;

    typedef enum logic [1:0] {
        PH_FREE,
        PH_INPUT,
        PH_PARTIAL,
        PH_DRAIN
    } sa_phase_e;

endpackage

/* hw/sysarr_control_unit.sv */
`timescale 1ns/10ps
`include "sys_arr_macros.svh"

module sysarr_control_unit import sys_arr_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  logic     stall,
    input  sa_load_t in_load,
    input  sa_load_t ps_load,
    output sa_ctrl_t ctrl,
    output logic     fifo_has_space,
    output logic     busy
);
    localparam int SLOTS = 3;   // GEMMs in flight at most

    typedef logic [`SA_ITER_W-1:0] iter_t;

    localparam iter_t   ITER_N    = iter_t'(`SA_N);
    localparam iter_t   ITER_2N   = iter_t'(2 * `SA_N);
    localparam iter_t   ITER_LAST = iter_t'(3 * `SA_N - 1);
    localparam sa_idx_t ROW_LAST  = sa_idx_t'(`SA_N - 1);

    iter_t [SLOTS-1:0] iter_q, iter_d;      // steps done per slot
    logic  [SLOTS-1:0] act_q, act_d;        // slot holds a GEMM
    sa_phase_e         phase [SLOTS];

    logic start_req;       // row 0 of a new GEMM is being written
    logic start_pend_q;    // row 0 arrived under stall, slot not yet taken
    logic start_take;

    logic [`SA_N-1:0] in_loaded_q, in_loaded_d;
    logic [`SA_N-1:0] ps_loaded_q, ps_loaded_d;
    logic             in_full_q, in_full_d;
    logic [1:0]       ps_full_q, ps_full_d;   // GEMMs whose partials are all in

    logic    in_act;
    logic    ps_act;
    logic    drain_act;
    iter_t   in_iter;
    iter_t   ps_iter;
    sa_idx_t in_k;
    sa_idx_t ps_k;
    logic    in_ok;
    logic    ps_ok;
    logic    fire;

    assign start_req = in_load.en && (in_load.row_idx == '0);

    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            if (!act_q[s]) phase[s] = PH_FREE;
            else if (iter_q[s] < ITER_N) phase[s] = PH_INPUT;
            else if (iter_q[s] < ITER_2N) phase[s] = PH_PARTIAL;
            else phase[s] = PH_DRAIN;
        end
    end

    // oldest slot in each phase is the one furthest along
    always_comb begin
        in_act    = 1'b0;
        ps_act    = 1'b0;
        drain_act = 1'b0;
        in_iter   = '0;
        ps_iter   = '0;
        for (int s = 0; s < SLOTS; s++) begin
            if (phase[s] == PH_INPUT && (!in_act || iter_q[s] > in_iter)) begin
                in_act  = 1'b1;
                in_iter = iter_q[s];
            end
            if (phase[s] == PH_PARTIAL && (!ps_act || iter_q[s] > ps_iter)) begin
                ps_act  = 1'b1;
                ps_iter = iter_q[s];
            end
            if (phase[s] == PH_DRAIN) drain_act = 1'b1;
        end
    end

    assign in_k  = sa_idx_t'(in_iter);
    assign ps_k  = sa_idx_t'(ps_iter - ITER_N);
    assign in_ok = !in_act || in_loaded_q[in_k] || in_full_q;
    assign ps_ok = !ps_act || ps_loaded_q[ps_k] || (ps_full_q != 2'd0);
    assign fire  = (|act_q) && in_ok && ps_ok && !stall;   // one step moves every slot

    always_comb begin
        ctrl.mac_start = fire;
        ctrl.in_shift  = fire && in_act;
        ctrl.ps_shift  = fire && ps_act;
        ctrl.add_start = fire && drain_act;
        ctrl.out_shift = fire && drain_act;
    end

    always_comb begin
        iter_d     = iter_q;
        act_d      = act_q;
        start_take = 1'b0;
        for (int s = 0; s < SLOTS; s++) begin
            if (act_q[s] && fire) begin
                if (iter_q[s] == ITER_LAST) begin   // last drain step frees the slot
                    act_d[s]  = 1'b0;
                    iter_d[s] = '0;
                end else begin
                    iter_d[s] = iter_q[s] + 1'b1;
                end
            end
        end
        for (int s = 0; s < SLOTS; s++) begin
            if (!act_q[s] && !start_take && (start_req || start_pend_q) && !stall) begin
                act_d[s]   = 1'b1;
                iter_d[s]  = '0;
                start_take = 1'b1;
            end
        end
    end

    always_comb begin
        in_loaded_d = in_loaded_q;
        ps_loaded_d = ps_loaded_q;
        in_full_d   = in_full_q;
        ps_full_d   = ps_full_q;
        if (ctrl.in_shift && in_k == ROW_LAST) in_full_d = 1'b0;
        if (ctrl.ps_shift && ps_k == ROW_LAST) ps_full_d = ps_full_q - 1'b1;
        if (in_load.en) in_loaded_d[in_load.row_idx] = 1'b1;
        if (ps_load.en) ps_loaded_d[ps_load.row_idx] = 1'b1;
        // a complete set collapses into the flag so the map can track the next GEMM
        if (&in_loaded_d) begin
            in_full_d   = 1'b1;
            in_loaded_d = '0;
        end
        if (&ps_loaded_d) begin
            ps_full_d   = ps_full_d + 1'b1;
            ps_loaded_d = '0;
        end
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            iter_q       <= '0;
            act_q        <= '0;
            start_pend_q <= 1'b0;
            in_loaded_q  <= '0;
            ps_loaded_q  <= '0;
            in_full_q    <= 1'b0;
            ps_full_q    <= '0;
        end else begin
            iter_q       <= iter_d;
            act_q        <= act_d;
            start_pend_q <= (start_req || start_pend_q) && !start_take;
            in_loaded_q  <= in_loaded_d;
            ps_loaded_q  <= ps_loaded_d;
            in_full_q    <= in_full_d;
            ps_full_q    <= ps_full_d;
        end
    end

    // a new GEMM may start only once nothing still needs the input or partial rows
    assign fifo_has_space = !in_act && !ps_act && !start_pend_q;
    assign busy           = (|act_q) || start_pend_q;

endmodule

/* hw/sysarr_mac_grid.sv */
`timescale 1ns/10ps
`include "sys_arr_macros.svh"

module sysarr_mac_grid import sys_arr_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  sa_load_t in_load,
    input  sa_load_t wt_load,
    input  sa_ctrl_t ctrl,
    output sa_row_t  prod_row
);
    localparam int IN_DEPTH = `SA_N;
    localparam int PR_DEPTH = 2 * `SA_N;   // products of one GEMM plus the next

    typedef logic [$clog2(IN_DEPTH)-1:0] in_ptr_t;
    typedef logic [$clog2(PR_DEPTH)-1:0] pr_ptr_t;

    sa_row_t w_mem  [`SA_N];      // row i holds W[i][*]
    sa_row_t in_mem [IN_DEPTH];
    sa_row_t pr_mem [PR_DEPTH];

    in_ptr_t in_wr;
    in_ptr_t in_rd;
    pr_ptr_t pr_wr;
    pr_ptr_t pr_rd;
    sa_row_t prod;   // head input row times W

    // wrap-around row-vector product, each term truncated to element width
    always_comb begin
        for (int j = 0; j < `SA_N; j++) begin
            prod[j] = '0;
            for (int i = 0; i < `SA_N; i++) begin
                prod[j] = prod[j] + sa_elem_t'(in_mem[in_rd][i] * w_mem[i][j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wt_load.en) w_mem[wt_load.row_idx] <= wt_load.data;
        if (in_load.en) in_mem[in_wr] <= in_load.data;
        if (ctrl.in_shift) pr_mem[pr_wr] <= prod;
        if (ctrl.ps_shift) prod_row <= pr_mem[pr_rd];   // registered pop
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            in_wr <= '0;
            in_rd <= '0;
            pr_wr <= '0;
            pr_rd <= '0;
        end else begin
            if (in_load.en) begin
                in_wr <= (in_wr == in_ptr_t'(IN_DEPTH - 1)) ? '0 : in_wr + 1'b1;
            end
            if (ctrl.in_shift) begin
                in_rd <= (in_rd == in_ptr_t'(IN_DEPTH - 1)) ? '0 : in_rd + 1'b1;
                pr_wr <= (pr_wr == pr_ptr_t'(PR_DEPTH - 1)) ? '0 : pr_wr + 1'b1;
            end
            if (ctrl.ps_shift) begin
                pr_rd <= (pr_rd == pr_ptr_t'(PR_DEPTH - 1)) ? '0 : pr_rd + 1'b1;
            end
        end
    end

endmodule

/* hw/sysarr_output_adder.sv */
`timescale 1ns/10ps
`include "sys_arr_macros.svh"

module sysarr_output_adder import sys_arr_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  sa_row_t  prod_row,
    input  sa_row_t  ps_row,
    input  sa_ctrl_t ctrl,
    output sa_out_t  out
);
    localparam int DEPTH = 2 * `SA_N;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    sa_row_t mem [DEPTH];   // sum FIFO

    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    logic    add_en;     // product and partial registers hold an aligned pair
    logic    pop;
    sa_row_t sum;
    sa_idx_t out_cnt;    // row number of the next result
    logic    out_valid;
    sa_idx_t out_idx;
    sa_row_t out_data;

    always_comb begin
        for (int j = 0; j < `SA_N; j++) sum[j] = prod_row[j] + ps_row[j];
    end

    assign pop = ctrl.add_start && ctrl.out_shift;

    always_ff @(posedge clk) begin
        if (add_en) mem[wr_ptr] <= sum;
        if (pop) out_data <= mem[rd_ptr];
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            add_en    <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_cnt   <= '0;
            out_valid <= 1'b0;
            out_idx   <= '0;
        end else begin
            add_en    <= ctrl.ps_shift;   // pops land one edge after the partial step
            out_valid <= pop;
            if (add_en) wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) begin
                rd_ptr  <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                out_idx <= out_cnt;
                out_cnt <= (out_cnt == sa_idx_t'(`SA_N - 1)) ? '0 : out_cnt + 1'b1;
            end
        end
    end

    assign out = '{valid: out_valid, row_idx: out_idx, data: out_data};

endmodule

/* hw/sysarr_partial_buffer.sv */
`timescale 1ns/10ps
`include "sys_arr_macros.svh"

module sysarr_partial_buffer import sys_arr_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  sa_load_t ps_load,
    input  sa_ctrl_t ctrl,
    output sa_row_t  ps_row
);
    localparam int DEPTH = 2 * `SA_N;   // two halves of one GEMM each

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;

    sa_row_t mem [DEPTH];

    logic    wr_bank;   // half that takes the rows of the GEMM being loaded
    sa_idx_t wr_cnt;    // rows of that GEMM received so far
    ptr_t    wr_addr;
    ptr_t    rd_ptr;

    // rows land by index, so they may arrive in any order within a GEMM
    assign wr_addr = wr_bank ? ptr_t'(`SA_N) + ptr_t'(ps_load.row_idx)
                             : ptr_t'(ps_load.row_idx);

    always_ff @(posedge clk) begin
        if (ps_load.en) mem[wr_addr] <= ps_load.data;
        if (ctrl.ps_shift) ps_row <= mem[rd_ptr];   // lines up with the product pop
    end

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            wr_bank <= 1'b0;
            wr_cnt  <= '0;
            rd_ptr  <= '0;
        end else begin
            if (ps_load.en) begin
                if (wr_cnt == sa_idx_t'(`SA_N - 1)) begin
                    wr_cnt  <= '0;
                    wr_bank <= !wr_bank;   // GEMM complete, next one uses the other half
                end else begin
                    wr_cnt <= wr_cnt + 1'b1;
                end
            end
            if (ctrl.ps_shift) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/sysarr_top.sv */
`timescale 1ns/10ps

module sysarr_top import sys_arr_pkg::*; (
    input  logic     clk,
    input  logic     nRST,
    input  sa_load_t in_load,
    input  sa_load_t ps_load,
    input  sa_load_t wt_load,
    input  logic     stall,
    output sa_out_t  out,
    output logic     fifo_has_space,
    output logic     busy
);
    sa_ctrl_t ctrl;       // step strobes
    sa_row_t  prod_row;   // grid product, aligned with ps_row
    sa_row_t  ps_row;

    sysarr_control_unit u_cu (
        .clk            (clk),
        .nRST           (nRST),
        .stall          (stall),
        .in_load        (in_load),
        .ps_load        (ps_load),
        .ctrl           (ctrl),
        .fifo_has_space (fifo_has_space),
        .busy           (busy)
    );

    sysarr_mac_grid u_grid (
        .clk      (clk),
        .nRST     (nRST),
        .in_load  (in_load),
        .wt_load  (wt_load),
        .ctrl     (ctrl),
        .prod_row (prod_row)
    );

    sysarr_partial_buffer u_pbuf (
        .clk     (clk),
        .nRST    (nRST),
        .ps_load (ps_load),
        .ctrl    (ctrl),
        .ps_row  (ps_row)
    );

    sysarr_output_adder u_adder (
        .clk      (clk),
        .nRST     (nRST),
        .prod_row (prod_row),
        .ps_row   (ps_row),
        .ctrl     (ctrl),
        .out      (out)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 --top-module sysarr_tb -Mdir "$BUILD_DIR" -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./"$BUILD_DIR"/Vsysarr_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* verification/sysarr_tb.sv */
`timescale 1ns/10ps
`include "sys_arr_macros.svh"

module sysarr_tb import sys_arr_pkg::*; ();
    localparam int N          = `SA_N;
    localparam int CLK_PERIOD = 10;
    localparam int GEMMS      = 3;

    // grid steps each test may take, the watchdog allows four cycles per step
    localparam int STEPS_RESET = 4;
    localparam int STEPS_IDENT = 3 * N + 8;
    localparam int STEPS_RAND  = 3 * N + 24;
    localparam int STEPS_B2B   = 3 * GEMMS * N + 12;
    localparam int STEPS_STALL = 3 * N + 80;
    localparam int WATCHDOG_CYCLES =
        4 * (STEPS_RESET + STEPS_IDENT + STEPS_RAND + STEPS_B2B + STEPS_STALL);

    logic      clk = 1'b0;
    logic      nRST;
    sa_load_t  in_load;
    sa_load_t  ps_load;
    sa_load_t  wt_load;
    logic      stall;
    sa_out_t   out;
    logic      fifo_has_space;
    logic      busy;

    sa_row_t   wt     [N];          // row i holds W[i][*]
    sa_row_t   a_rows [GEMMS][N];
    sa_row_t   p_rows [GEMMS][N];
    sa_row_t   exp_q  [$];          // expected rows in issue order
    sa_out_t   out_q  [$];          // rows seen on the output
    int        errors       = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    logic      stall_prev   = 1'b0;
    sa_phase_e slot_phase;

    sysarr_top u_dut (
        .clk            (clk),
        .nRST           (nRST),
        .in_load        (in_load),
        .ps_load        (ps_load),
        .wt_load        (wt_load),
        .stall          (stall),
        .out            (out),
        .fifo_has_space (fifo_has_space),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (nRST && out.valid) out_q.push_back(out);
        if (nRST && stall_prev && out.valid) begin
            slot_phase = u_dut.u_cu.phase[0];
            $display("out.valid at %0t after a cycle of stall (slot 0 in %s)",
                     $time, slot_phase.name());
            errors++;
        end
        stall_prev = stall;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT never delivered the awaited rows",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_row(input string name, input sa_row_t exp, input sa_row_t act);
        if (act !== exp) begin
            $display("** Error: %0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_out_idx(input string name, input sa_idx_t exp, input sa_idx_t act);
        if (act !== exp) begin
            $display("** Error: %0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error: %0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: fail with %0d errors", tests_run, name, errors - errs_before);
        end
    endtask

    // out = in x W + ps, every element kept modulo 2^16
    task automatic ref_gemm(input int g);
        sa_row_t r;
        int      acc;
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                acc = int'(p_rows[g][k][j]);
                for (int i = 0; i < N; i++) begin
                    acc = acc + int'(a_rows[g][k][i]) * int'(wt[i][j]);
                end
                r[j] = sa_elem_t'(acc);
            end
            exp_q.push_back(r);
        end
    endtask

    task automatic fill_random(input int g);
        for (int k = 0; k < N; k++) begin
            for (int j = 0; j < N; j++) begin
                a_rows[g][k][j] = sa_elem_t'($urandom);
                p_rows[g][k][j] = sa_elem_t'($urandom);
            end
        end
    endtask

    task automatic random_weights();
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) wt[i][j] = sa_elem_t'($urandom);
        end
    endtask

    task automatic load_weights();
        for (int i = 0; i < N; i++) begin
            wt_load = '{en: 1'b1, row_idx: sa_idx_t'(i), data: wt[i]};
            tick();
        end
        wt_load = '0;
    endtask

    // a new GEMM goes in only while the DUT has room for it
    task automatic load_inputs(input int g);
        while (!fifo_has_space) tick();
        ref_gemm(g);
        for (int k = 0; k < N; k++) begin
            in_load = '{en: 1'b1, row_idx: sa_idx_t'(k), data: a_rows[g][k]};
            tick();
        end
        in_load = '0;
    endtask

    task automatic load_partials(input int g);
        for (int k = 0; k < N; k++) begin
            ps_load = '{en: 1'b1, row_idx: sa_idx_t'(k), data: p_rows[g][k]};
            tick();
        end
        ps_load = '0;
    endtask

    task automatic stall_bursts(input int count);
        int gap;
        int len;
        for (int b = 0; b < count; b++) begin
            gap = int'($urandom_range(3, 0));
            len = int'($urandom_range(6, 1));
            repeat (gap) tick();
            stall = 1'b1;
            repeat (len) tick();
            stall = 1'b0;
        end
    endtask

    // rows must come back in issue order, numbered 0 to N-1 per GEMM
    task automatic collect_results(input int n);
        sa_out_t got;
        sa_row_t exp_row;
        for (int r = 0; r < n; r++) begin
            while (out_q.size() == 0) tick();
            got     = out_q.pop_front();
            exp_row = exp_q.pop_front();
            check_out_idx("out.row_idx", sa_idx_t'(r % N), got.row_idx);
            check_row("out.data", exp_row, got.data);
        end
        // the last drain step frees the last slot one cycle before its row shows
        check_flag("busy", 1'b0, busy);
        repeat (3) tick();
        if (out_q.size() != 0) begin
            $display("%0d output rows appeared after the last GEMM had finished", out_q.size());
            errors++;
            out_q.delete();
        end
    endtask

    task automatic test_reset_state();
        int errs_before;
        errs_before = errors;
        tick();
        check_flag("out.valid", 1'b0, out.valid);
        check_flag("busy", 1'b0, busy);
        check_flag("fifo_has_space", 1'b1, fifo_has_space);
        report_test("reset state", errs_before);
    endtask

    task automatic test_identity();
        int errs_before;
        errs_before = errors;
        for (int i = 0; i < N; i++) begin
            wt[i]     = '0;
            wt[i][i]  = 16'sd1;
            p_rows[0][i] = '0;
        end
        fill_random(1);
        a_rows[0] = a_rows[1];
        load_weights();
        load_inputs(0);
        load_partials(0);
        collect_results(N);
        check_flag("busy", 1'b0, busy);
        check_flag("fifo_has_space", 1'b1, fifo_has_space);
        report_test("identity weights", errs_before);
    endtask

    task automatic test_late_partials();
        int errs_before;
        errs_before = errors;
        random_weights();
        fill_random(0);
        a_rows[0][N-1] = {N{16'h7fff}};   // large products that wrap
        p_rows[0][0]   = {N{16'hffff}};
        load_weights();
        load_inputs(0);
        repeat (15) tick();
        load_partials(0);
        collect_results(N);
        report_test("random GEMM, late partials", errs_before);
    endtask

    task automatic test_back_to_back();
        int errs_before;
        errs_before = errors;
        random_weights();
        load_weights();
        for (int g = 0; g < GEMMS; g++) begin
            fill_random(g);
            load_inputs(g);
            load_partials(g);
        end
        collect_results(GEMMS * N);
        report_test("back-to-back GEMMs", errs_before);
    endtask

    task automatic test_stall();
        int errs_before;
        errs_before = errors;
        random_weights();
        fill_random(0);
        load_weights();
        fork
            stall_bursts(6);
            begin
                load_inputs(0);
                load_partials(0);
            end
        join
        collect_results(N);
        report_test("stall during GEMM", errs_before);
    endtask

    initial begin
        void'($urandom(32'ha014_5ddf));
        nRST    = 1'b0;
        in_load = '0;
        ps_load = '0;
        wt_load = '0;
        stall   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        nRST = 1'b1;

        test_reset_state();
        test_identity();
        test_late_partials();
        test_back_to_back();
        test_stall();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hw
hw/sys_arr_pkg.sv
hw/sysarr_control_unit.sv
hw/sysarr_mac_grid.sv
hw/sysarr_partial_buffer.sv
hw/sysarr_output_adder.sv
hw/sysarr_top.sv
verification/sysarr_tb.sv
